// ==== mem_arb.sv ====
`timescale 1ns/1ps

module mem_arb (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            ifu_req_valid,
  output logic                            ifu_req_ready,
  input  logic [mem_read_pkg::ADDR_W-1:0] ifu_req_addr,
  output logic                            ifu_resp_valid,
  input  logic                            ifu_resp_ready,
  output mem_read_pkg::rd_resp_t          ifu_resp,
  input  logic                            lsu_req_valid,
  output logic                            lsu_req_ready,
  input  logic [mem_read_pkg::ADDR_W-1:0] lsu_req_addr,
  output logic                            lsu_resp_valid,
  input  logic                            lsu_resp_ready,
  output mem_read_pkg::rd_resp_t          lsu_resp,
  output logic                            arb_req_valid,
  input  logic                            arb_req_ready,
  output mem_read_pkg::rd_req_t           arb_req,
  input  logic                            ram_resp_valid,
  output logic                            ram_resp_ready,
  input  mem_read_pkg::rd_resp_t          ram_resp
);
  import mem_read_pkg::*;

  // per-master vectors are indexed by src_e
  logic [1:0]        req_valid;
  logic [ADDR_W-1:0] req_addr [2];
  logic [1:0]        req_fire;
  logic [1:0]        skid_valid;
  logic [ADDR_W-1:0] skid_addr [2];
  logic [1:0]        cand_valid;
  logic [ADDR_W-1:0] cand_addr [2];
  logic              out_free;
  logic              grant_valid;
  src_e              grant;
  src_e              last_grant;

  logic [1:0]        resp_ready;
  logic [1:0]        resp_valid_q;
  rd_resp_t          resp_q [2];
  logic [1:0]        slot_free;
  logic              hold_valid;
  rd_resp_t          hold;
  logic              hold_move;
  logic              ram_fire;
  logic              ram_direct;
  logic [1:0]        load;
  rd_resp_t          load_data;

  assign req_valid          = {lsu_req_valid, ifu_req_valid};
  assign req_addr[SRC_IFU]  = ifu_req_addr;
  assign req_addr[SRC_LSU]  = lsu_req_addr;
  assign req_fire           = req_valid & ~skid_valid;
  assign ifu_req_ready      = ~skid_valid[SRC_IFU];
  assign lsu_req_ready      = ~skid_valid[SRC_LSU];

  // a stored request takes precedence over the live address
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      cand_valid[i] = skid_valid[i] | req_valid[i];
      cand_addr[i]  = skid_valid[i] ? skid_addr[i] : req_addr[i];
    end
  end

  assign out_free    = ~arb_req_valid | arb_req_ready;
  assign grant_valid = out_free & (|cand_valid);

  always_comb begin
    if (&cand_valid) begin
      grant = (last_grant == SRC_IFU) ? SRC_LSU : SRC_IFU;  // round robin
    end else if (cand_valid[SRC_LSU]) begin
      grant = SRC_LSU;
    end else begin
      grant = SRC_IFU;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      arb_req_valid <= 1'b0;
      skid_valid    <= '0;
      last_grant    <= SRC_IFU;  // lsu wins the first tie
    end else begin
      if (arb_req_valid && arb_req_ready) begin
        arb_req_valid <= 1'b0;
      end
      if (grant_valid) begin
        arb_req_valid <= 1'b1;
        last_grant    <= grant;
      end
      for (int i = 0; i < 2; i++) begin
        if (grant_valid && grant == src_e'(i)) begin
          skid_valid[i] <= 1'b0;
        end else if (req_fire[i]) begin
          skid_valid[i] <= 1'b1;  // lost or stalled, park it
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_valid) begin
      arb_req.addr <= cand_addr[grant];
      arb_req.src  <= grant;
    end
    for (int i = 0; i < 2; i++) begin
      if (req_fire[i]) begin
        skid_addr[i] <= req_addr[i];
      end
    end
  end

  // return path
  assign resp_ready     = {lsu_resp_ready, ifu_resp_ready};
  assign slot_free      = ~resp_valid_q | resp_ready;
  assign ram_resp_ready = ~hold_valid;
  assign ram_fire       = ram_resp_valid & ~hold_valid;
  assign hold_move      = hold_valid & slot_free[hold.src];
  assign ram_direct     = ram_fire & slot_free[ram_resp.src];
  assign load_data      = hold_valid ? hold : ram_resp;

  always_comb begin
    load = '0;
    if (hold_move) begin
      load[hold.src] = 1'b1;
    end else if (ram_direct) begin
      load[ram_resp.src] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      resp_valid_q <= '0;
      hold_valid   <= 1'b0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (load[i]) begin
          resp_valid_q[i] <= 1'b1;
        end else if (resp_ready[i]) begin
          resp_valid_q[i] <= 1'b0;
        end
      end
      if (hold_move) begin
        hold_valid <= 1'b0;
      end else if (ram_fire && !ram_direct) begin
        hold_valid <= 1'b1;  // target master still busy
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (load[i]) begin
        resp_q[i] <= load_data;
      end
    end
    if (ram_fire) begin
      hold <= ram_resp;  // only kept when not routed directly
    end
  end

  assign ifu_resp_valid = resp_valid_q[SRC_IFU];
  assign ifu_resp       = resp_q[SRC_IFU];
  assign lsu_resp_valid = resp_valid_q[SRC_LSU];
  assign lsu_resp       = resp_q[SRC_LSU];

endmodule

// ==== mem_read_pkg.sv ====
package mem_read_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int RAM_WORDS   = 64;  // byte addresses 0..255
  localparam int RAM_LAT     = 2;   // accept to rvalid
  localparam int QUEUE_DEPTH = 2;

  // derived widths
  localparam int WORD_IDX_W = $clog2(RAM_WORDS);
  localparam int QPTR_W     = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int QCNT_W     = $clog2(QUEUE_DEPTH + 1);
  localparam int LAT_W      = (RAM_LAT > 1) ? $clog2(RAM_LAT) : 1;

  typedef enum logic {
    SRC_IFU = 1'b0,
    SRC_LSU = 1'b1
  } src_e;

  // same codes as axi rresp
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } rresp_e;

  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_BUSY,
    RAM_RESP
  } ram_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    src_e              src;
  } rd_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    rresp_e            resp;
    src_e              src;   // routes the response back
  } rd_resp_t;

endpackage

// ==== mem_read_tb.sv ====
`timescale 1ns/1ps

module mem_read_tb;
  import mem_read_pkg::*;

  localparam int N_DIR     = 21;
  localparam int N_RND     = 40;
  localparam int N_ENTRIES = N_DIR + N_RND;
  localparam int WD_CYCLES = N_ENTRIES * 40 + 100;

  typedef struct packed {
    src_e              src;
    logic [ADDR_W-1:0] addr;
    logic [3:0]        stall;  // cycles of resp_ready low
  } entry_t;

  logic                   clk;
  logic                   rstn;
  logic [1:0]             req_valid;
  logic [1:0][ADDR_W-1:0] req_addr;
  logic [1:0]             resp_ready;
  logic                   ifu_req_ready;
  logic                   lsu_req_ready;
  logic                   ifu_resp_valid;
  logic                   lsu_resp_valid;
  rd_resp_t               ifu_resp;
  rd_resp_t               lsu_resp;
  logic [1:0]             req_ready;
  logic [1:0]             resp_valid;
  rd_resp_t [1:0]         resp;

  logic [DATA_W-1:0] ref_mem [RAM_WORDS];
  entry_t            tbl [N_ENTRIES];
  int                n_tbl;
  entry_t            pend_ifu [$];
  entry_t            pend_lsu [$];
  logic [31:0]       rnd_state;

  // indexed by src_e
  assign req_ready  = {lsu_req_ready, ifu_req_ready};
  assign resp_valid = {lsu_resp_valid, ifu_resp_valid};
  assign resp       = {lsu_resp, ifu_resp};

  mem_read_top UUT (
    .clk            (clk),
    .rstn           (rstn),
    .ifu_req_valid  (req_valid[SRC_IFU]),
    .ifu_req_ready  (ifu_req_ready),
    .ifu_req_addr   (req_addr[SRC_IFU]),
    .ifu_resp_valid (ifu_resp_valid),
    .ifu_resp_ready (resp_ready[SRC_IFU]),
    .ifu_resp       (ifu_resp),
    .lsu_req_valid  (req_valid[SRC_LSU]),
    .lsu_req_ready  (lsu_req_ready),
    .lsu_req_addr   (req_addr[SRC_LSU]),
    .lsu_resp_valid (lsu_resp_valid),
    .lsu_resp_ready (resp_ready[SRC_LSU]),
    .lsu_resp       (lsu_resp)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // not word aligned or beyond the ram gives slverr
  function automatic logic addr_bad(input logic [ADDR_W-1:0] a);
    return (a % 4 != 0) || (a / 4 >= RAM_WORDS);
  endfunction

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_resp(input string name, input rresp_e exp, input rresp_e act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      $display("Test failed");
      $fatal(1, "response code mismatch");
    end
  endtask

  task automatic add_entry(input src_e s, input logic [ADDR_W-1:0] a, input int stall);
    tbl[n_tbl].src   = s;
    tbl[n_tbl].addr  = a;
    tbl[n_tbl].stall = 4'(stall);
    n_tbl++;
  endtask

  task automatic issue(input src_e s, input int lo, input int hi);
    for (int i = lo; i < hi; i++) begin
      if (tbl[i].src == s) begin
        req_valid[s] = 1'b1;
        req_addr[s]  = tbl[i].addr;
        while (!req_ready[s]) @(negedge clk);  // transfer on the next rising edge
        if (s == SRC_IFU)
          pend_ifu.push_back(tbl[i]);
        else
          pend_lsu.push_back(tbl[i]);
        @(negedge clk);
      end
    end
    req_valid[s] = 1'b0;
  endtask

  task automatic collect(input src_e s, input int lo, input int hi);
    entry_t            e;
    logic [DATA_W-1:0] exp_data;
    rresp_e            exp_code;
    string             tag;
    tag = (s == SRC_IFU) ? "ifu_resp" : "lsu_resp";
    for (int i = lo; i < hi; i++) begin
      if (tbl[i].src == s) begin
        while ((s == SRC_IFU ? pend_ifu.size() : pend_lsu.size()) == 0) @(negedge clk);
        if (s == SRC_IFU)
          e = pend_ifu.pop_front();
        else
          e = pend_lsu.pop_front();
        exp_data = addr_bad(e.addr) ? '0 : ref_mem[e.addr[ADDR_W-1:2]];
        exp_code = addr_bad(e.addr) ? RESP_SLVERR : RESP_OKAY;
        resp_ready[s] = (e.stall == 0);
        while (!resp_valid[s]) @(negedge clk);
        repeat (e.stall) @(negedge clk);  // back-pressure
        check_data({tag, ".data"}, exp_data, resp[s].data);
        check_resp({tag, ".resp"}, exp_code, resp[s].resp);
        resp_ready[s] = 1'b1;
        @(negedge clk);
      end
    end
  endtask

  task automatic run_range(input int lo, input int hi);
    fork
      issue(SRC_IFU, lo, hi);
      issue(SRC_LSU, lo, hi);
      collect(SRC_IFU, lo, hi);
      collect(SRC_LSU, lo, hi);
    join
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    int                p1;
    int                p2;
    int                p3;
    logic [31:0]       r;
    logic [ADDR_W-1:0] a;
    rstn       = 1'b1;
    req_valid  = '0;
    req_addr   = '0;
    resp_ready = 2'b11;
    n_tbl      = 0;
    rnd_state  = 32'h1728;
    $readmemh("ram_init.hex", ref_mem);

    add_entry(SRC_IFU, 32'h00, 0);  // single reads, ifu alone
    add_entry(SRC_IFU, 32'h04, 0);
    add_entry(SRC_IFU, 32'h08, 0);
    add_entry(SRC_IFU, 32'h3C, 0);
    p1 = n_tbl;
    add_entry(SRC_LSU, 32'h80, 0);
    add_entry(SRC_LSU, 32'h84, 0);
    add_entry(SRC_LSU, 32'hC0, 0);
    add_entry(SRC_LSU, 32'hF8, 0);
    p2 = n_tbl;
    add_entry(SRC_IFU, 32'h20, 0);  // both masters at once
    add_entry(SRC_LSU, 32'h24, 0);
    add_entry(SRC_IFU, 32'h28, 0);
    add_entry(SRC_LSU, 32'h2C, 0);
    add_entry(SRC_IFU, 32'h02, 0);  // misaligned
    add_entry(SRC_LSU, 32'h100, 0);  // just past the end
    add_entry(SRC_IFU, 32'h30, 0);
    add_entry(SRC_LSU, 32'hFC, 0);
    add_entry(SRC_IFU, 32'hFFFF_FFFC, 0);
    add_entry(SRC_IFU, 32'h40, 8);  // ifu stalls, lsu keeps going
    add_entry(SRC_LSU, 32'h44, 0);
    add_entry(SRC_LSU, 32'h48, 0);
    add_entry(SRC_LSU, 32'h4C, 0);
    p3 = n_tbl;
    for (int i = 0; i < N_RND; i++) begin
      rnd_state = xorshift(rnd_state);
      r = rnd_state;
      case (r[7:4])
        4'h0:    a = {24'h0, r[15:8]};
        4'h1:    a = 32'h100 + {24'h0, r[15:8]};
        default: a = {24'h0, r[13:8], 2'b00};
      endcase
      rnd_state = xorshift(rnd_state);
      add_entry(src_e'(r[0]), a, rnd_state[3] ? int'(rnd_state[2:0]) + 1 : 0);
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b0;
    run_range(0, p1);
    run_range(p1, p2);
    run_range(p2, p3);
    run_range(p3, n_tbl);
    if (UUT.u_hs_check.fail_cnt == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "bound assertions reported errors");
    end
  end

  // also stops early on a bound assertion error
  initial begin
    int cyc;
    cyc = 0;
    while (cyc < WD_CYCLES && UUT.u_hs_check.fail_cnt == 0) begin
      @(posedge clk);
      cyc++;
    end
    if (UUT.u_hs_check.fail_cnt != 0)
      $display("A bound handshake or reset assertion failed");
    else
      $display("Timeout: responses stopped before all table entries completed");
    $display("Test failed");
    $fatal(1, "run aborted");
  end

endmodule

// ==== mem_read_tb_assert.sv ====
`timescale 1ns/1ps

module mem_read_tb_assert (
  input logic                   clk,
  input logic                   rstn,
  input logic                   ifu_resp_valid,
  input logic                   ifu_resp_ready,
  input mem_read_pkg::rd_resp_t ifu_resp,
  input logic                   lsu_resp_valid,
  input logic                   lsu_resp_ready,
  input mem_read_pkg::rd_resp_t lsu_resp,
  input logic                   arb_req_valid,
  input logic                   q_req_valid,
  input logic                   ram_resp_valid
);

  int fail_cnt = 0;  // polled by the testbench

  ifu_hold: assert property (@(posedge clk) disable iff (rstn)
    ifu_resp_valid && !ifu_resp_ready |=> ifu_resp_valid && $stable(ifu_resp))
  else begin
    fail_cnt++;
    $error("ifu response changed while stalled");
  end

  lsu_hold: assert property (@(posedge clk) disable iff (rstn)
    lsu_resp_valid && !lsu_resp_ready |=> lsu_resp_valid && $stable(lsu_resp))
  else begin
    fail_cnt++;
    $error("lsu response changed while stalled");
  end

  // first cycle out of reset
  reset_clear: assert property (@(posedge clk)
    $fell(rstn) |-> !(ifu_resp_valid || lsu_resp_valid || arb_req_valid ||
                      q_req_valid || ram_resp_valid))
  else begin
    fail_cnt++;
    $error("valid output set in the first cycle after reset");
  end

  in_reset: assert property (@(posedge clk)
    rstn |=> !(ifu_resp_valid || lsu_resp_valid || ram_resp_valid))
  else begin
    fail_cnt++;
    $error("response valid raised during reset");
  end

endmodule

bind mem_read_top mem_read_tb_assert u_hs_check (
  .clk            (clk),
  .rstn           (rstn),
  .ifu_resp_valid (ifu_resp_valid),
  .ifu_resp_ready (ifu_resp_ready),
  .ifu_resp       (ifu_resp),
  .lsu_resp_valid (lsu_resp_valid),
  .lsu_resp_ready (lsu_resp_ready),
  .lsu_resp       (lsu_resp),
  .arb_req_valid  (arb_req_valid),
  .q_req_valid    (q_req_valid),
  .ram_resp_valid (ram_resp_valid)
);

// ==== mem_read_top.f ====
mem_read_pkg.sv
mem_arb.sv
ram_req_queue.sv
ram_read_port.sv
mem_read_top.sv
mem_read_tb_assert.sv
mem_read_tb.sv

// ==== mem_read_top.sv ====
`timescale 1ns/1ps

module mem_read_top (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            ifu_req_valid,
  output logic                            ifu_req_ready,
  input  logic [mem_read_pkg::ADDR_W-1:0] ifu_req_addr,
  output logic                            ifu_resp_valid,
  input  logic                            ifu_resp_ready,
  output mem_read_pkg::rd_resp_t          ifu_resp,
  input  logic                            lsu_req_valid,
  output logic                            lsu_req_ready,
  input  logic [mem_read_pkg::ADDR_W-1:0] lsu_req_addr,
  output logic                            lsu_resp_valid,
  input  logic                            lsu_resp_ready,
  output mem_read_pkg::rd_resp_t          lsu_resp
);
  import mem_read_pkg::*;

  logic     arb_req_valid;
  logic     arb_req_ready;
  rd_req_t  arb_req;
  logic     q_req_valid;
  logic     q_req_ready;
  rd_req_t  q_req;
  logic     ram_resp_valid;
  logic     ram_resp_ready;
  rd_resp_t ram_resp;

  mem_arb u_arb (
    .clk            (clk),
    .rstn           (rstn),
    .ifu_req_valid  (ifu_req_valid),
    .ifu_req_ready  (ifu_req_ready),
    .ifu_req_addr   (ifu_req_addr),
    .ifu_resp_valid (ifu_resp_valid),
    .ifu_resp_ready (ifu_resp_ready),
    .ifu_resp       (ifu_resp),
    .lsu_req_valid  (lsu_req_valid),
    .lsu_req_ready  (lsu_req_ready),
    .lsu_req_addr   (lsu_req_addr),
    .lsu_resp_valid (lsu_resp_valid),
    .lsu_resp_ready (lsu_resp_ready),
    .lsu_resp       (lsu_resp),
    .arb_req_valid  (arb_req_valid),
    .arb_req_ready  (arb_req_ready),
    .arb_req        (arb_req),
    .ram_resp_valid (ram_resp_valid),
    .ram_resp_ready (ram_resp_ready),
    .ram_resp       (ram_resp)
  );

  ram_req_queue u_queue (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (arb_req_valid),
    .in_ready  (arb_req_ready),
    .in_req    (arb_req),
    .out_valid (q_req_valid),
    .out_ready (q_req_ready),
    .out_req   (q_req)
  );

  ram_read_port u_ram (
    .clk        (clk),
    .rstn       (rstn),
    .req_valid  (q_req_valid),
    .req_ready  (q_req_ready),
    .req        (q_req),
    .resp_valid (ram_resp_valid),
    .resp_ready (ram_resp_ready),
    .resp       (ram_resp)
  );

endmodule

// ==== ram_init.hex ====
// one 32-bit word per line, word 0 first: a5, word index, 16'hffff minus byte address
A500FFFF
A501FFFB
A502FFF7
A503FFF3
A504FFEF
A505FFEB
A506FFE7
A507FFE3
A508FFDF
A509FFDB
A50AFFD7
A50BFFD3
A50CFFCF
A50DFFCB
A50EFFC7
A50FFFC3
A510FFBF
A511FFBB
A512FFB7
A513FFB3
A514FFAF
A515FFAB
A516FFA7
A517FFA3
A518FF9F
A519FF9B
A51AFF97
A51BFF93
A51CFF8F
A51DFF8B
A51EFF87
A51FFF83
A520FF7F
A521FF7B
A522FF77
A523FF73
A524FF6F
A525FF6B
A526FF67
A527FF63
A528FF5F
A529FF5B
A52AFF57
A52BFF53
A52CFF4F
A52DFF4B
A52EFF47
A52FFF43
A530FF3F
A531FF3B
A532FF37
A533FF33
A534FF2F
A535FF2B
A536FF27
A537FF23
A538FF1F
A539FF1B
A53AFF17
A53BFF13
A53CFF0F
A53DFF0B
A53EFF07
A53FFF03

// ==== ram_read_port.sv ====
`timescale 1ns/1ps

module ram_read_port (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  mem_read_pkg::rd_req_t  req,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output mem_read_pkg::rd_resp_t resp
);
  import mem_read_pkg::*;

  logic [DATA_W-1:0]     ram [RAM_WORDS];
  ram_state_e            state;
  logic [LAT_W-1:0]      lat_cnt;
  rd_req_t               req_q;
  logic                  addr_err;
  logic [WORD_IDX_W-1:0] word_idx;
  logic                  accept;
  logic                  lat_done;

  initial begin
    $readmemh("ram_init.hex", ram);
  end

  assign req_ready  = (state == RAM_IDLE);
  assign resp_valid = (state == RAM_RESP);
  assign accept     = req_valid & req_ready;
  assign lat_done   = (state == RAM_BUSY) && (lat_cnt == '0);

  // misaligned or past the last word
  assign addr_err = (req_q.addr[1:0] != 2'b00) ||
                    (req_q.addr >= ADDR_W'(RAM_WORDS * 4));
  assign word_idx = req_q.addr[WORD_IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (rstn) begin
      state   <= RAM_IDLE;
      lat_cnt <= '0;
    end else begin
      case (state)
        RAM_IDLE: begin
          if (accept) begin
            state   <= RAM_BUSY;
            lat_cnt <= LAT_W'(RAM_LAT - 1);
          end
        end
        RAM_BUSY: begin
          if (lat_done) begin
            state <= RAM_RESP;
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        RAM_RESP: begin
          if (resp_ready) begin
            state <= RAM_IDLE;  // resp stays put until taken
          end
        end
        default: state <= RAM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
    if (lat_done) begin
      resp.src <= req_q.src;
      if (addr_err) begin
        resp.data <= '0;
        resp.resp <= RESP_SLVERR;
      end else begin
        resp.data <= ram[word_idx];
        resp.resp <= RESP_OKAY;
      end
    end
  end

endmodule

// ==== ram_req_queue.sv ====
`timescale 1ns/1ps

module ram_req_queue (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  mem_read_pkg::rd_req_t in_req,
  output logic                  out_valid,
  input  logic                  out_ready,
  output mem_read_pkg::rd_req_t out_req
);
  import mem_read_pkg::*;

  rd_req_t           mem [QUEUE_DEPTH];
  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QCNT_W-1:0] count;
  logic              full;
  logic              push;
  logic              pop;

  assign full      = (count == QCNT_W'(QUEUE_DEPTH));
  assign out_valid = (count != '0);
  assign in_ready  = ~full | out_ready;  // full queue still takes one on a pop
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;
  assign out_req   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_req;
    end
  end

endmodule
